// ==== src/cp0_consts.svh ====
`ifndef CP0_CONSTS_SVH
`define CP0_CONSTS_SVH

// ----------------------------------------
// CP0 register numbers
// ----------------------------------------
`define CP0_REG_BADVADDR 5'd8
`define CP0_REG_COUNT    5'd9
`define CP0_REG_COMPARE  5'd11
`define CP0_REG_STATUS   5'd12
`define CP0_REG_CAUSE    5'd13
`define CP0_REG_EPC      5'd14
`define CP0_REG_PRID     5'd15
`define CP0_REG_CONFIG   5'd16

// ----------------------------------------
// selected exception kind (exc_type_t)
// ----------------------------------------
`define EXC_TYPE_NONE 4'd0
`define EXC_TYPE_INT  4'd1
`define EXC_TYPE_ADEL 4'd2
`define EXC_TYPE_RI   4'd3
`define EXC_TYPE_OV   4'd4
`define EXC_TYPE_SYS  4'd5
`define EXC_TYPE_BP   4'd6
`define EXC_TYPE_ADES 4'd7
`define EXC_TYPE_ERET 4'd8

// bit positions inside exc_flags_t.
`define EXC_FLAG_ADEL 0
`define EXC_FLAG_RI   1
`define EXC_FLAG_OV   2
`define EXC_FLAG_SYS  3
`define EXC_FLAG_BP   4
`define EXC_FLAG_ADES 5
`define EXC_FLAG_ERET 6

// Cause.ExcCode values.
`define EXC_CODE_INT  5'd0
`define EXC_CODE_ADEL 5'd4
`define EXC_CODE_ADES 5'd5
`define EXC_CODE_SYS  5'd8
`define EXC_CODE_BP   5'd9
`define EXC_CODE_RI   5'd10
`define EXC_CODE_OV   5'd12

`define STATUS_RESET     32'h0040_0000
`define CONFIG_RESET     32'h0000_8000
`define PRID_RESET       32'h004c_0102
`define EXC_HANDLER_ADDR 32'hbfc0_0380

`endif

// ==== src/cp0_pkg.sv ====
`default_nettype none

package cp0_pkg;

   // ----------------------------------------
   // datapath widths
   // ----------------------------------------
   typedef logic [31:0] word_t;     // data, address or register value.

   typedef logic [4:0] cp0_addr_t;  // CP0 register number.

   // ----------------------------------------
   // exception handling
   // ----------------------------------------
   typedef logic [4:0] exc_code_t;  // Cause.ExcCode field.

   // one bit per memory-stage source, adel in bit 0 up to eret in bit 6.
   typedef logic [6:0] exc_flags_t;

   // none, int, adel, ri, ov, sys, bp, ades or eret.
   typedef logic [3:0] exc_type_t;

endpackage : cp0_pkg

`default_nettype wire

// ==== src/cp0_regs.sv ====
`include "cp0_consts.svh"
`default_nettype none

module cp0_regs (
   input  wire logic                clk,
   input  wire logic                rst,
   input  wire logic                we_i,
   input  wire cp0_pkg::cp0_addr_t  waddr_i,
   input  wire cp0_pkg::word_t      wdata_i,
   input  wire cp0_pkg::cp0_addr_t  raddr_i,
   output cp0_pkg::word_t           rdata_o,
   input  wire logic                exc_en_i,
   input  wire cp0_pkg::exc_type_t  exc_type_i,
   input  wire cp0_pkg::word_t      pc_i,
   input  wire logic                in_delayslot_i,
   input  wire cp0_pkg::word_t      badvaddr_i,
   input  wire logic [5:0]          int_i,
   output cp0_pkg::word_t           status_o,
   output cp0_pkg::word_t           cause_o,
   output cp0_pkg::word_t           epc_o,
   output logic                     timer_int_o
);

   cp0_pkg::word_t count_q;
   cp0_pkg::word_t compare_q;
   cp0_pkg::word_t status_q;
   cp0_pkg::word_t cause_q;
   cp0_pkg::word_t epc_q;
   cp0_pkg::word_t badvaddr_q;
   logic           timer_int_q;

   cp0_pkg::word_t status_d;
   cp0_pkg::word_t cause_d;
   cp0_pkg::word_t epc_d;
   cp0_pkg::word_t badvaddr_d;

   logic wr_count;
   logic wr_compare;
   logic wr_status;
   logic wr_cause;
   logic wr_epc;

   function automatic cp0_pkg::exc_code_t exc_code(input cp0_pkg::exc_type_t t);
      cp0_pkg::exc_code_t code;
      case (t)
         `EXC_TYPE_ADEL: code = `EXC_CODE_ADEL;
         `EXC_TYPE_RI:   code = `EXC_CODE_RI;
         `EXC_TYPE_OV:   code = `EXC_CODE_OV;
         `EXC_TYPE_SYS:  code = `EXC_CODE_SYS;
         `EXC_TYPE_BP:   code = `EXC_CODE_BP;
         `EXC_TYPE_ADES: code = `EXC_CODE_ADES;
         default:        code = `EXC_CODE_INT;
      endcase
      return code;
   endfunction

   // ----------------------------------------
   // mtc0 decode and write-merged view
   // ----------------------------------------
   assign wr_count   = we_i && (waddr_i == `CP0_REG_COUNT);
   assign wr_compare = we_i && (waddr_i == `CP0_REG_COMPARE);
   assign wr_status  = we_i && (waddr_i == `CP0_REG_STATUS);
   assign wr_cause   = we_i && (waddr_i == `CP0_REG_CAUSE);
   assign wr_epc     = we_i && (waddr_i == `CP0_REG_EPC);

   always_comb begin
      status_o = status_q;
      if (wr_status) begin
         status_o[0]    = wdata_i[0];     // ie.
         status_o[15:8] = wdata_i[15:8];  // im.
      end
   end

   always_comb begin
      cause_o = cause_q;
      if (wr_cause) begin
         cause_o[9:8] = wdata_i[9:8];     // software interrupts.
      end
   end

   assign epc_o = wr_epc ? wdata_i : epc_q;

   // ----------------------------------------
   // exception commit on top of mtc0 data
   // ----------------------------------------
   always_comb begin
      status_d   = status_o;
      cause_d    = cause_o;
      epc_d      = epc_o;
      badvaddr_d = badvaddr_q;
      // hw lines land one cycle late, timer shares ip7.
      cause_d[15:10] = {int_i[5] | timer_int_q, int_i[4:0]};
      if (exc_en_i) begin
         if (exc_type_i == `EXC_TYPE_ERET) begin
            status_d[1] = 1'b0;           // leave exception level.
         end else begin
            status_d[1]  = 1'b1;
            cause_d[6:2] = exc_code(exc_type_i);
            cause_d[31]  = in_delayslot_i;
            epc_d        = in_delayslot_i ? pc_i - 32'd4 : pc_i;
            if (exc_type_i == `EXC_TYPE_ADEL || exc_type_i == `EXC_TYPE_ADES) begin
               badvaddr_d = badvaddr_i;
            end
         end
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         status_q   <= `STATUS_RESET;
         cause_q    <= '0;
         epc_q      <= '0;
         badvaddr_q <= '0;
      end else begin
         status_q   <= status_d;
         cause_q    <= cause_d;
         epc_q      <= epc_d;
         badvaddr_q <= badvaddr_d;
      end
   end

   // ----------------------------------------
   // Count/Compare timer
   // ----------------------------------------
   always_ff @(posedge clk) begin
      if (rst) begin
         count_q <= '0;
      end else if (wr_count) begin
         count_q <= wdata_i;
      end else begin
         count_q <= count_q + 32'd1;
      end
   end

   always_ff @(posedge clk) begin
      if (rst) begin
         compare_q   <= '0;
         timer_int_q <= 1'b0;
      end else if (wr_compare) begin
         compare_q   <= wdata_i;
         timer_int_q <= 1'b0;             // acknowledge.
      end else if (compare_q != '0 && count_q == compare_q) begin
         timer_int_q <= 1'b1;
      end
   end

   assign timer_int_o = timer_int_q;

   // mfc0 read sees register state only.
   always_comb begin
      case (raddr_i)
         `CP0_REG_BADVADDR: rdata_o = badvaddr_q;
         `CP0_REG_COUNT:    rdata_o = count_q;
         `CP0_REG_COMPARE:  rdata_o = compare_q;
         `CP0_REG_STATUS:   rdata_o = status_q;
         `CP0_REG_CAUSE:    rdata_o = cause_q;
         `CP0_REG_EPC:      rdata_o = epc_q;
         `CP0_REG_PRID:     rdata_o = `PRID_RESET;
         `CP0_REG_CONFIG:   rdata_o = `CONFIG_RESET;
         default:           rdata_o = '0;
      endcase
   end

endmodule : cp0_regs

`default_nettype wire

// ==== src/except_ctrl.sv ====
`include "cp0_consts.svh"
`default_nettype none

module except_ctrl (
   input  wire logic                 valid_i,
   input  wire cp0_pkg::exc_flags_t  flags_i,
   input  wire cp0_pkg::word_t       status_i,
   input  wire cp0_pkg::word_t       cause_i,
   input  wire cp0_pkg::word_t       epc_i,
   output cp0_pkg::exc_type_t        exc_type_o,
   output logic                      exc_en_o,
   output logic                      flush_o,
   output cp0_pkg::word_t            new_pc_o
);

   logic       ie;
   logic       exl;
   logic [7:0] ip_masked;
   logic       int_pending;

   // ----------------------------------------
   // interrupt pending
   // ----------------------------------------
   assign ie          = status_i[0];
   assign exl         = status_i[1];
   assign ip_masked   = cause_i[15:8] & status_i[15:8];
   assign int_pending = ie && !exl && (ip_masked != 8'd0);

   // ----------------------------------------
   // fixed priority select
   // ----------------------------------------
   always_comb begin
      exc_type_o = `EXC_TYPE_NONE;
      if (valid_i) begin
         if (int_pending) begin
            exc_type_o = `EXC_TYPE_INT;    // interrupts beat sync faults.
         end else if (flags_i[`EXC_FLAG_ADEL]) begin
            exc_type_o = `EXC_TYPE_ADEL;
         end else if (flags_i[`EXC_FLAG_RI]) begin
            exc_type_o = `EXC_TYPE_RI;
         end else if (flags_i[`EXC_FLAG_OV]) begin
            exc_type_o = `EXC_TYPE_OV;
         end else if (flags_i[`EXC_FLAG_SYS]) begin
            exc_type_o = `EXC_TYPE_SYS;
         end else if (flags_i[`EXC_FLAG_BP]) begin
            exc_type_o = `EXC_TYPE_BP;
         end else if (flags_i[`EXC_FLAG_ADES]) begin
            exc_type_o = `EXC_TYPE_ADES;
         end else if (flags_i[`EXC_FLAG_ERET]) begin
            exc_type_o = `EXC_TYPE_ERET;
         end
      end
   end

   assign exc_en_o = valid_i && (exc_type_o != `EXC_TYPE_NONE);

   // every commit, eret included, kills the younger stages.
   assign flush_o  = exc_en_o;

   // ----------------------------------------
   // redirect target
   // ----------------------------------------
   always_comb begin
      if (exc_type_o == `EXC_TYPE_ERET) begin
         new_pc_o = epc_i;                 // epc already write-merged.
      end else begin
         new_pc_o = `EXC_HANDLER_ADDR;
      end
   end

endmodule : except_ctrl

`default_nettype wire

// ==== src/cp0_top.sv ====
`default_nettype none

module cp0_top (
   input  wire logic                 clk,
   input  wire logic                 rst,
   input  wire logic [5:0]           int_i,
   input  wire logic                 mem_valid_i,
   input  wire cp0_pkg::word_t       mem_pc_i,
   input  wire logic                 mem_in_delayslot_i,
   input  wire cp0_pkg::exc_flags_t  mem_flags_i,
   input  wire cp0_pkg::word_t       mem_badvaddr_i,
   input  wire logic                 wb_cp0_we_i,
   input  wire cp0_pkg::cp0_addr_t   wb_cp0_waddr_i,
   input  wire cp0_pkg::word_t       wb_cp0_wdata_i,
   input  wire cp0_pkg::cp0_addr_t   cp0_raddr_i,
   output cp0_pkg::word_t            cp0_rdata_o,
   output logic                      flush_o,
   output cp0_pkg::word_t            new_pc_o,
   output logic                      timer_int_o
);

   // write-merged registers toward the selector.
   cp0_pkg::word_t     status;
   cp0_pkg::word_t     cause;
   cp0_pkg::word_t     epc;
   cp0_pkg::exc_type_t exc_type;
   logic               exc_en;

   except_ctrl except_ctrl_i (
      .valid_i    (mem_valid_i),
      .flags_i    (mem_flags_i),
      .status_i   (status),
      .cause_i    (cause),
      .epc_i      (epc),
      .exc_type_o (exc_type),
      .exc_en_o   (exc_en),
      .flush_o    (flush_o),
      .new_pc_o   (new_pc_o)
   );

   cp0_regs cp0_regs_i (
      .clk            (clk),
      .rst            (rst),
      .we_i           (wb_cp0_we_i),
      .waddr_i        (wb_cp0_waddr_i),
      .wdata_i        (wb_cp0_wdata_i),
      .raddr_i        (cp0_raddr_i),
      .rdata_o        (cp0_rdata_o),
      .exc_en_i       (exc_en),
      .exc_type_i     (exc_type),
      .pc_i           (mem_pc_i),
      .in_delayslot_i (mem_in_delayslot_i),
      .badvaddr_i     (mem_badvaddr_i),
      .int_i          (int_i),
      .status_o       (status),
      .cause_o        (cause),
      .epc_o          (epc),
      .timer_int_o    (timer_int_o)
   );

endmodule : cp0_top

`default_nettype wire

// ==== test/tb_clock.sv ====
`default_nettype none

module tb_clock (
   output logic clk_o
);

   timeunit 1ns;
   timeprecision 1ps;

   initial begin
      clk_o = 1'b0;
   end

   always #50 clk_o = ~clk_o;  // 100 ns period.

endmodule : tb_clock

`default_nettype wire

// ==== test/cp0_properties.sv ====
`include "cp0_consts.svh"
`default_nettype none

module cp0_properties (
   input wire logic                clk,
   input wire logic                rst,
   input wire logic                flush_o,
   input wire cp0_pkg::word_t      new_pc_o,
   input wire logic                timer_int_o,
   input wire logic                wb_cp0_we_i,
   input wire cp0_pkg::cp0_addr_t  wb_cp0_waddr_i,
   input wire cp0_pkg::exc_type_t  exc_type
);

   timeunit 1ns;
   timeprecision 1ps;

   no_flush_in_reset: assert property (@(posedge clk) rst |-> !flush_o)
      else $error("flush_o high while rst is asserted");

   handler_target: assert property (@(posedge clk) disable iff (rst)
      (flush_o && exc_type != `EXC_TYPE_ERET) |-> new_pc_o == `EXC_HANDLER_ADDR)
      else $error("exception redirect does not point at the handler");

   // ack comes only from an mtc0 to Compare.
   timer_ack: assert property (@(posedge clk) disable iff (rst)
      $fell(timer_int_o) |-> $past(wb_cp0_we_i && wb_cp0_waddr_i == `CP0_REG_COMPARE))
      else $error("timer_int_o dropped without a Compare write");

endmodule : cp0_properties

`default_nettype wire

// ==== test/cp0_tb.sv ====
`include "cp0_consts.svh"
`default_nettype none

module cp0_tb;

   timeunit 1ns;
   timeprecision 1ps;

   logic                clk;
   logic                rst;
   logic [5:0]          int_in;
   logic                mem_valid;
   cp0_pkg::word_t      mem_pc;
   logic                mem_ds;
   cp0_pkg::exc_flags_t mem_flags;
   cp0_pkg::word_t      mem_badv;
   logic                cp0_we;
   cp0_pkg::cp0_addr_t  cp0_waddr;
   cp0_pkg::word_t      cp0_wdata;
   cp0_pkg::cp0_addr_t  cp0_raddr;
   cp0_pkg::word_t      cp0_rdata;
   logic                flush;
   cp0_pkg::word_t      new_pc;
   logic                timer_int;
   logic                last_exc;
   int                  n;

   // ----------------------------------------
   // reference model state
   // ----------------------------------------
   cp0_pkg::word_t m_count   = '0;
   cp0_pkg::word_t m_compare = '0;
   cp0_pkg::word_t m_status  = `STATUS_RESET;
   cp0_pkg::word_t m_cause   = '0;
   cp0_pkg::word_t m_epc     = '0;
   cp0_pkg::word_t m_badv    = '0;
   logic           m_timer   = 1'b0;

   tb_clock tb_clock_i (.clk_o(clk));

   cp0_top cp0_top_i (
      .clk                (clk),
      .rst                (rst),
      .int_i              (int_in),
      .mem_valid_i        (mem_valid),
      .mem_pc_i           (mem_pc),
      .mem_in_delayslot_i (mem_ds),
      .mem_flags_i        (mem_flags),
      .mem_badvaddr_i     (mem_badv),
      .wb_cp0_we_i        (cp0_we),
      .wb_cp0_waddr_i     (cp0_waddr),
      .wb_cp0_wdata_i     (cp0_wdata),
      .cp0_raddr_i        (cp0_raddr),
      .cp0_rdata_o        (cp0_rdata),
      .flush_o            (flush),
      .new_pc_o           (new_pc),
      .timer_int_o        (timer_int)
   );

   bind cp0_top cp0_properties cp0_properties_i (
      .clk            (clk),
      .rst            (rst),
      .flush_o        (flush_o),
      .new_pc_o       (new_pc_o),
      .timer_int_o    (timer_int_o),
      .wb_cp0_we_i    (wb_cp0_we_i),
      .wb_cp0_waddr_i (wb_cp0_waddr_i),
      .exc_type       (exc_type)
   );

   task automatic fail_run();
      $display("Simulation failed");
      $fatal(1, "stopping at the first error");
   endtask

   task automatic check_word(input string name, input cp0_pkg::word_t exp,
                             input cp0_pkg::word_t act);
      if (act !== exp) begin
         $display("** Error %s: expected %h, actual %h", name, exp, act);
         fail_run();
      end
   endtask

   task automatic check_flush(input string name, input logic exp, input logic act);
      if (act !== exp) begin
         $display("** Error %s: expected %b, actual %b", name, exp, act);
         fail_run();
      end
   endtask

   task automatic check_type(input string name, input cp0_pkg::exc_code_t exp,
                             input cp0_pkg::exc_code_t act);
      if (act !== exp) begin
         $display("** Error %s: expected %0d, actual %0d", name, exp, act);
         fail_run();
      end
   endtask

   function automatic cp0_pkg::exc_type_t select_exc(input logic v, input cp0_pkg::exc_flags_t f,
                                                     input cp0_pkg::word_t st,
                                                     input cp0_pkg::word_t ca);
      cp0_pkg::exc_type_t t;
      t = `EXC_TYPE_NONE;
      // lowest priority first, the last hit wins.
      for (int i = 6; i >= 0; i--) begin
         if (v && f[i]) t = `EXC_TYPE_ADEL + 4'(i);
      end
      if (v && st[0] && !st[1] && (ca[15:8] & st[15:8]) != 8'd0) t = `EXC_TYPE_INT;
      return t;
   endfunction

   function automatic cp0_pkg::exc_code_t code_of(input cp0_pkg::exc_type_t t);
      case (t)
         `EXC_TYPE_ADEL: return `EXC_CODE_ADEL;
         `EXC_TYPE_ADES: return `EXC_CODE_ADES;
         `EXC_TYPE_RI:   return `EXC_CODE_RI;
         `EXC_TYPE_OV:   return `EXC_CODE_OV;
         `EXC_TYPE_SYS:  return `EXC_CODE_SYS;
         `EXC_TYPE_BP:   return `EXC_CODE_BP;
         default:        return `EXC_CODE_INT;
      endcase
   endfunction

   function automatic cp0_pkg::word_t model_read(input cp0_pkg::cp0_addr_t a);
      case (a)
         `CP0_REG_BADVADDR: return m_badv;
         `CP0_REG_COUNT:    return m_count;
         `CP0_REG_COMPARE:  return m_compare;
         `CP0_REG_STATUS:   return m_status;
         `CP0_REG_CAUSE:    return m_cause;
         `CP0_REG_EPC:      return m_epc;
         `CP0_REG_PRID:     return `PRID_RESET;
         `CP0_REG_CONFIG:   return `CONFIG_RESET;
         default:           return '0;
      endcase
   endfunction

   // ----------------------------------------
   // per-cycle check and model step
   // ----------------------------------------
   task automatic check_cycle();
      cp0_pkg::word_t     st;
      cp0_pkg::word_t     ca;
      cp0_pkg::word_t     epc;
      cp0_pkg::exc_type_t t;
      @(negedge clk);
      st = m_status;
      if (cp0_we && cp0_waddr == `CP0_REG_STATUS) begin
         st[0]    = cp0_wdata[0];
         st[15:8] = cp0_wdata[15:8];
      end
      ca = m_cause;
      if (cp0_we && cp0_waddr == `CP0_REG_CAUSE) ca[9:8] = cp0_wdata[9:8];
      epc = (cp0_we && cp0_waddr == `CP0_REG_EPC) ? cp0_wdata : m_epc;
      t = select_exc(mem_valid, mem_flags, st, ca);
      check_flush("flush", t != `EXC_TYPE_NONE, flush);
      if (t != `EXC_TYPE_NONE) begin
         check_word("new_pc", (t == `EXC_TYPE_ERET) ? epc : `EXC_HANDLER_ADDR, new_pc);
      end
      check_flush("timer_int", m_timer, timer_int);
      if (cp0_raddr == `CP0_REG_CAUSE) check_type("exc_code", m_cause[6:2], cp0_rdata[6:2]);
      check_word("mfc0", model_read(cp0_raddr), cp0_rdata);
      ca[15:10] = {int_in[5] | m_timer, int_in[4:0]};  // old timer value.
      if (t == `EXC_TYPE_ERET) begin
         st[1] = 1'b0;
      end else if (t != `EXC_TYPE_NONE) begin
         st[1]   = 1'b1;
         ca[6:2] = code_of(t);
         ca[31]  = mem_ds;
         epc     = mem_ds ? mem_pc - 32'd4 : mem_pc;
         if (t == `EXC_TYPE_ADEL || t == `EXC_TYPE_ADES) m_badv = mem_badv;
      end
      if (cp0_we && cp0_waddr == `CP0_REG_COMPARE) begin
         m_compare = cp0_wdata;
         m_timer   = 1'b0;
      end else if (m_compare != '0 && m_count == m_compare) begin
         m_timer = 1'b1;
      end
      m_count  = (cp0_we && cp0_waddr == `CP0_REG_COUNT) ? cp0_wdata : m_count + 32'd1;
      m_status = st;
      m_cause  = ca;
      m_epc    = epc;
      last_exc = t != `EXC_TYPE_NONE && t != `EXC_TYPE_ERET;
   endtask

   task automatic drive(input logic we, input cp0_pkg::cp0_addr_t wa, input cp0_pkg::word_t wd,
                        input logic valid, input cp0_pkg::exc_flags_t fl,
                        input cp0_pkg::cp0_addr_t ra);
      @(posedge clk);
      rst       <= 1'b0;
      cp0_we    <= we;
      cp0_waddr <= wa;
      cp0_wdata <= wd;
      mem_valid <= valid;
      mem_flags <= fl;
      cp0_raddr <= ra;
      mem_pc    <= 32'h8000_0100;
      mem_ds    <= 1'b0;
      mem_badv  <= '0;
      int_in    <= '0;
      check_cycle();
   endtask

   task automatic drive_random();
      cp0_pkg::cp0_addr_t wa;
      cp0_pkg::word_t     wd;
      case ($urandom % 6)
         0:       wa = `CP0_REG_COUNT;
         1:       wa = `CP0_REG_COMPARE;
         2:       wa = `CP0_REG_STATUS;
         3:       wa = `CP0_REG_CAUSE;
         4:       wa = `CP0_REG_EPC;
         default: wa = 5'($urandom);
      endcase
      // compare lands a few cycles ahead of count.
      wd = (wa == `CP0_REG_COMPARE) ? m_count + 32'($urandom % 32) + 32'd2 : $urandom;
      @(posedge clk);
      cp0_we    <= ($urandom % 4) == 0;
      cp0_waddr <= wa;
      cp0_wdata <= wd;
      mem_valid <= 1'($urandom);
      mem_flags <= 7'($urandom & $urandom & $urandom);
      mem_pc    <= $urandom & 32'hffff_fffc;
      mem_ds    <= 1'($urandom);
      mem_badv  <= $urandom;
      int_in    <= 6'($urandom & $urandom & $urandom);
      cp0_raddr <= last_exc ? `CP0_REG_CAUSE : 5'($urandom % 18);
      check_cycle();
   endtask

   initial begin
      void'($urandom(45119));
      rst       = 1'b1;
      int_in    = '0;
      mem_valid = 1'b0;
      mem_pc    = '0;
      mem_ds    = 1'b0;
      mem_flags = '0;
      mem_badv  = '0;
      cp0_we    = 1'b0;
      cp0_waddr = '0;
      cp0_wdata = '0;
      cp0_raddr = '0;
      last_exc  = 1'b0;
      repeat (15) @(posedge clk);
      for (int a = 0; a < 32; a++) drive(1'b0, '0, '0, 1'b0, '0, 5'(a));
      repeat (4000) drive_random();

      // eret with EPC written in the same cycle.
      drive(1'b1, `CP0_REG_STATUS, 32'h0, 1'b0, '0, `CP0_REG_STATUS);
      drive(1'b0, '0, '0, 1'b1, 7'b000_1000, `CP0_REG_STATUS);  // syscall sets exl.
      drive(1'b1, `CP0_REG_EPC, 32'h8000_2000, 1'b1, 7'b100_0000, `CP0_REG_EPC);
      check_word("eret_pc", 32'h8000_2000, new_pc);
      drive(1'b0, '0, '0, 1'b0, '0, `CP0_REG_STATUS);
      check_flush("eret_exl", 1'b0, cp0_rdata[1]);

      // ----------------------------------------
      // timer up to Compare, then taken as ip7
      // ----------------------------------------
      drive(1'b1, `CP0_REG_COUNT, 32'h0, 1'b0, '0, `CP0_REG_COUNT);
      drive(1'b1, `CP0_REG_COMPARE, 32'd20, 1'b0, '0, `CP0_REG_COMPARE);
      drive(1'b0, '0, '0, 1'b0, '0, `CP0_REG_COMPARE);
      check_word("compare_wr", 32'd20, cp0_rdata);
      n = 0;
      while (!timer_int && n < 100) begin
         drive(1'b0, '0, '0, 1'b0, '0, `CP0_REG_COUNT);
         n++;
      end
      if (!timer_int) begin
         $display("timer interrupt never asserted after Count reached Compare");
         fail_run();
      end
      drive(1'b1, `CP0_REG_STATUS, 32'h0000_8001, 1'b0, '0, `CP0_REG_CAUSE);
      drive(1'b0, '0, '0, 1'b1, '0, `CP0_REG_CAUSE);
      check_flush("timer_irq", 1'b1, flush);
      drive(1'b0, '0, '0, 1'b0, '0, `CP0_REG_CAUSE);
      check_type("timer_irq_code", `EXC_CODE_INT, cp0_rdata[6:2]);
      drive(1'b1, `CP0_REG_COMPARE, 32'h0, 1'b0, '0, `CP0_REG_COMPARE);
      drive(1'b0, '0, '0, 1'b0, '0, `CP0_REG_COMPARE);
      check_flush("timer_ack", 1'b0, timer_int);

      $display("Simulation completed successfully");
      $finish;
   end

endmodule : cp0_tb

`default_nettype wire

// ==== src.f ====
+incdir+src
src/cp0_pkg.sv
src/cp0_regs.sv
src/except_ctrl.sv
src/cp0_top.sv
test/tb_clock.sv
test/cp0_properties.sv
test/cp0_tb.sv

// ==== Makefile ====
TOP := cp0_tb

.PHONY: all lint clean

all: obj_dir/V$(TOP)
	./obj_dir/V$(TOP)

obj_dir/V$(TOP): src.f $(wildcard src/*.sv src/*.svh test/*.sv)
	verilator --binary --timing --assert -f src.f --top-module $(TOP)

lint:
	verilator --lint-only --timing -Wall -f src.f --top-module $(TOP)

clean:
	rm -rf obj_dir
